// File: pwm_audio_top.f
hw/pwm_audio_pkg.sv
hw/sample_fetch.sv
hw/pwm_modulator.sv
hw/delay_line.sv
hw/delay_table_loader.sv
hw/speaker_tap.sv
hw/pwm_audio_top.sv
sim/pwm_audio_checker.sv
sim/pwm_audio_tb.sv

// File: Bender.yml
package:
  name: pwm_audio

sources:
  - hw/pwm_audio_pkg.sv
  - hw/sample_fetch.sv
  - hw/pwm_modulator.sv
  - hw/delay_line.sv
  - hw/delay_table_loader.sv
  - hw/speaker_tap.sv
  - hw/pwm_audio_top.sv
  - target: simulation
    files:
      - sim/pwm_audio_checker.sv
      - sim/pwm_audio_tb.sv

// File: sim/pwm_audio_tb.sv
// testbench for the speaker player with a fixed seed and all checks held in the bound checker
`timescale 1ns/1ps
`default_nettype none

module pwm_audio_tb;

  localparam int RESET_CYCLES    = 16;
  localparam int WATCHDOG_CYCLES = 20 * pwm_audio_pkg::SAMPLE_PERIOD + 2000;

  logic                                   PWM_ADC_CLOCK_100M;
  logic                                   arst_n;
  pwm_audio_pkg::fifo_in_t                audio_fifo;
  logic                                   audio_read;
  pwm_audio_pkg::fifo_in_t                delay_fifo;
  logic                                   delay_read;
  logic                                   pwm_out;
  logic [pwm_audio_pkg::NUM_CHANNELS-1:0] speakers;
  int                                     timeouts;

  always #5 PWM_ADC_CLOCK_100M = ~PWM_ADC_CLOCK_100M;   // 100 MHz

  pwm_audio_top u_pwm_audio_top (
    .PWM_ADC_CLOCK_100M (PWM_ADC_CLOCK_100M),
    .arst_n             (arst_n),
    .audio_fifo         (audio_fifo),
    .audio_read         (audio_read),
    .delay_fifo         (delay_fifo),
    .delay_read         (delay_read),
    .pwm_out            (pwm_out),
    .speakers           (speakers)
  );

  // ============================================================
  // stimulus helpers
  // ============================================================
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge PWM_ADC_CLOCK_100M);
  endtask

  // random word that never looks like a frame marker
  function automatic logic [pwm_audio_pkg::FIFO_W-1:0] data_word();
    logic [pwm_audio_pkg::FIFO_W-1:0] w;
    w = $urandom();
    if (w == pwm_audio_pkg::FRAME_MARKER) begin
      w = w ^ 'h1;
    end
    return w;
  endfunction

  // one constant level on the audio FIFO for whole periods
  task automatic play_sample(input int periods);
    int unsigned                      level;
    logic [pwm_audio_pkg::FIFO_W-1:0] word;
    level = $urandom_range(1000, 0);
    word  = $urandom();                                 // upper bits are noise
    word[pwm_audio_pkg::SAMPLE_W-1:0] = level[pwm_audio_pkg::SAMPLE_W-1:0];
    @(posedge PWM_ADC_CLOCK_100M);
    audio_fifo <= {1'b1, word};
    wait_cycles(periods * pwm_audio_pkg::SAMPLE_PERIOD - 1);
  endtask

  task automatic audio_gap(input int cycles);
    @(posedge PWM_ADC_CLOCK_100M);
    audio_fifo.avail <= 1'b0;                           // FIFO runs dry
    wait_cycles(cycles - 1);
  endtask

  task automatic push_word(input logic [pwm_audio_pkg::FIFO_W-1:0] word);
    @(posedge PWM_ADC_CLOCK_100M);
    delay_fifo <= {1'b1, word};
    if ($urandom_range(3, 0) == 0) begin
      @(posedge PWM_ADC_CLOCK_100M);
      delay_fifo.avail <= 1'b0;                         // occasional empty cycle
    end
  endtask

  // strays, opening marker, entries, closing marker
  task automatic send_frame(input int entries, input int strays);
    repeat (strays) push_word(data_word());
    push_word(pwm_audio_pkg::FRAME_MARKER);
    repeat (entries) push_word(data_word());
    push_word(pwm_audio_pkg::FRAME_MARKER);
    @(posedge PWM_ADC_CLOCK_100M);
    delay_fifo <= '0;
  endtask

  task automatic finish_run();
    int fails;
    fails = u_pwm_audio_top.u_pwm_audio_checker.fail_count;
    $display("errors: %0d assertion failures, %0d timeouts", fails, timeouts);
    if (fails == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    void'($urandom(62));
    PWM_ADC_CLOCK_100M = 1'b0;
    arst_n             = 1'b0;
    audio_fifo         = {1'b1, data_word()};           // both FIFOs full during reset
    delay_fifo         = {1'b1, pwm_audio_pkg::FRAME_MARKER};
    timeouts           = 0;
    wait_cycles(RESET_CYCLES);
    arst_n     <= 1'b1;
    delay_fifo <= '0;                                   // loader starts idle
    play_sample(3);                                     // all delays still 0
    send_frame(8, 3);                                   // strays before the frame
    play_sample(3);
    audio_gap(1500);                                    // at least one skipped read
    play_sample(2);
    send_frame(10, 0);                                  // two extra entries dropped
    send_frame(3, 1);                                   // rewrites channels 0 to 2 only
    play_sample(3);
    wait_cycles(20);
    finish_run();
  end

  // watchdog
  initial begin
    wait_cycles(WATCHDOG_CYCLES);
    $display("error: timeout, stimulus still running after %0d cycles", WATCHDOG_CYCLES);
    timeouts++;
    finish_run();
  end

endmodule : pwm_audio_tb

`default_nettype wire

// File: sim/pwm_audio_checker.sv
// passive checker bound into pwm_audio_top and it expects audio samples within 0 to 1000
`timescale 1ns/1ps
`default_nettype none

module pwm_audio_checker (
  input wire logic                                   PWM_ADC_CLOCK_100M,
  input wire logic                                   arst_n,
  input wire pwm_audio_pkg::fifo_in_t                audio_fifo,
  input wire logic                                   audio_read,
  input wire pwm_audio_pkg::fifo_in_t                delay_fifo,
  input wire logic                                   delay_read,
  input wire logic                                   pwm_out,
  input wire logic [pwm_audio_pkg::NUM_CHANNELS-1:0] speakers
);

  int fail_count = 0;                                   // read by the testbench at the end

  // ============================================================
  // delay table model and pulse history
  // ============================================================
  logic [pwm_audio_pkg::DELAY_W-1:0]      table_m [pwm_audio_pkg::NUM_CHANNELS];
  logic                                   in_frame;
  int                                     frame_idx;
  int                                     settle_cnt;   // cycles until a write reaches speakers
  logic [pwm_audio_pkg::DELAY_DEPTH:0]    hist_m;       // bit n is pwm_out n+1 cycles back
  logic [pwm_audio_pkg::NUM_CHANNELS-1:0] exp_speakers;

  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      in_frame   <= 1'b0;
      frame_idx  <= 0;
      settle_cnt <= 0;
      hist_m     <= '0;
      for (int k = 0; k < pwm_audio_pkg::NUM_CHANNELS; k++) begin
        table_m[k] <= '0;                               // all delays zero after reset
      end
    end else begin
      hist_m <= {hist_m[pwm_audio_pkg::DELAY_DEPTH-1:0], pwm_out};
      if (settle_cnt > 0) begin
        settle_cnt <= settle_cnt - 1;
      end
      if (delay_fifo.avail) begin
        if (delay_fifo.data == pwm_audio_pkg::FRAME_MARKER) begin
          in_frame  <= !in_frame;                       // open or close
          frame_idx <= 0;
        end else if (in_frame && frame_idx < pwm_audio_pkg::NUM_CHANNELS) begin
          table_m[frame_idx] <= delay_fifo.data[pwm_audio_pkg::DELAY_W-1:0];
          frame_idx          <= frame_idx + 1;
          settle_cnt         <= 3;                      // strobe, register, tap
        end
        // strays and entries past channel 7 change nothing
      end
    end
  end

  always_comb begin
    for (int k = 0; k < pwm_audio_pkg::NUM_CHANNELS; k++) begin
      exp_speakers[k] = hist_m[int'(table_m[k]) + 1];   // pwm_out 2+delay cycles back
    end
  end

  // ============================================================
  // sample and pulse density model
  // ============================================================
  logic [pwm_audio_pkg::SAMPLE_W-1:0] sample_m;         // last captured level
  logic                               seen_read;
  logic                               warm;             // window right after a level change
  int                                 gap_cnt;
  int                                 phase;
  int                                 ones;
  int                                 ones_total;
  logic                               density_ok;

  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      sample_m  <= '0;
      seen_read <= 1'b0;
      warm      <= 1'b1;
      gap_cnt   <= 0;
      phase     <= 0;
      ones      <= 0;
    end else begin
      gap_cnt <= audio_read ? 1 : gap_cnt + 1;
      if (audio_read) begin
        sample_m  <= audio_fifo.data[pwm_audio_pkg::SAMPLE_W-1:0];
        warm      <= !seen_read || (audio_fifo.data[pwm_audio_pkg::SAMPLE_W-1:0] != sample_m);
        seen_read <= 1'b1;
      end else if (phase == pwm_audio_pkg::SAMPLE_PERIOD - 1) begin
        warm <= 1'b0;                                   // level held through a gap
      end
      if (audio_read || phase == pwm_audio_pkg::SAMPLE_PERIOD - 1) begin
        phase <= 0;                                     // new window
        ones  <= 0;
      end else begin
        phase <= phase + 1;
        ones  <= ones + int'(pwm_out);
      end
    end
  end

  assign ones_total = ones + int'(pwm_out);             // window incl. its last cycle
  assign density_ok = (ones_total <= int'(sample_m) + 1) && (ones_total + 1 >= int'(sample_m));

  // ============================================================
  // assertions
  // ============================================================
  reset_quiet_a: assert property (@(posedge PWM_ADC_CLOCK_100M)
      ((!arst_n && $past(!arst_n)) || $rose(arst_n)) |->
      (!audio_read && !delay_read && !pwm_out && speakers == '0))
    else begin
      $error("outputs not quiet at %0t during or right after reset", $time);
      fail_count++;
    end

  read_avail_a: assert property (@(posedge PWM_ADC_CLOCK_100M) disable iff (!arst_n)
      audio_read |-> audio_fifo.avail)
    else begin
      $error("audio_read high at %0t while the audio FIFO is empty", $time);
      fail_count++;
    end

  read_single_a: assert property (@(posedge PWM_ADC_CLOCK_100M) disable iff (!arst_n)
      audio_read |=> !audio_read)
    else begin
      $error("audio_read held high for more than one cycle at %0t", $time);
      fail_count++;
    end

  read_spacing_a: assert property (@(posedge PWM_ADC_CLOCK_100M) disable iff (!arst_n)
      (audio_read && seen_read) |-> (gap_cnt % pwm_audio_pkg::SAMPLE_PERIOD == 0))
    else begin
      $error("mismatch at %0t: audio_read spacing got %0d expected a multiple of %0d",
             $time, $sampled(gap_cnt), pwm_audio_pkg::SAMPLE_PERIOD);
      fail_count++;
    end

  density_a: assert property (@(posedge PWM_ADC_CLOCK_100M) disable iff (!arst_n)
      (seen_read && !warm && phase == pwm_audio_pkg::SAMPLE_PERIOD - 1) |-> density_ok)
    else begin
      $error("mismatch at %0t: pwm_out ones per period got %0d expected %0d",
             $time, $sampled(ones_total), $sampled(sample_m));
      fail_count++;
    end

  speaker_a: assert property (@(posedge PWM_ADC_CLOCK_100M) disable iff (!arst_n)
      (settle_cnt == 0) |-> (speakers == exp_speakers))
    else begin
      $error("mismatch at %0t: speakers got %b expected %b",
             $time, $sampled(speakers), $sampled(exp_speakers));
      fail_count++;
    end

  delay_read_a: assert property (@(posedge PWM_ADC_CLOCK_100M) disable iff (!arst_n)
      delay_read == delay_fifo.avail)
    else begin
      $error("mismatch at %0t: delay_read got %b expected %b",
             $time, $sampled(delay_read), $sampled(delay_fifo.avail));
      fail_count++;
    end

endmodule : pwm_audio_checker

bind pwm_audio_top pwm_audio_checker u_pwm_audio_checker (
  .PWM_ADC_CLOCK_100M (PWM_ADC_CLOCK_100M),
  .arst_n             (arst_n),
  .audio_fifo         (audio_fifo),
  .audio_read         (audio_read),
  .delay_fifo         (delay_fifo),
  .delay_read         (delay_read),
  .pwm_out            (pwm_out),
  .speakers           (speakers)
);

`default_nettype wire

// File: hw/pwm_audio_top.sv
// speaker array player top with both FIFOs show-ahead and no stall on any path
`timescale 1ns/1ps
`default_nettype none

module pwm_audio_top (
  input  wire logic                                   PWM_ADC_CLOCK_100M,
  input  wire logic                                   arst_n,
  input  wire pwm_audio_pkg::fifo_in_t                audio_fifo,
  output logic                                        audio_read,
  input  wire pwm_audio_pkg::fifo_in_t                delay_fifo,
  output logic                                        delay_read,
  output logic                                        pwm_out,
  output logic [pwm_audio_pkg::NUM_CHANNELS-1:0]      speakers
);

  logic [pwm_audio_pkg::SAMPLE_W-1:0]    sample;    // current audio level
  logic [pwm_audio_pkg::DELAY_DEPTH-1:0] history;   // past pulses
  pwm_audio_pkg::delay_wr_t              delay_wr;  // table write broadcast

  // ============================================================
  // audio path
  // ============================================================
  sample_fetch u_sample_fetch (
    .PWM_ADC_CLOCK_100M (PWM_ADC_CLOCK_100M),
    .arst_n             (arst_n),
    .audio_fifo         (audio_fifo),
    .audio_read         (audio_read),
    .sample             (sample)
  );

  pwm_modulator u_pwm_modulator (
    .PWM_ADC_CLOCK_100M (PWM_ADC_CLOCK_100M),
    .arst_n             (arst_n),
    .sample             (sample),
    .pwm_out            (pwm_out)
  );

  delay_line u_delay_line (
    .PWM_ADC_CLOCK_100M (PWM_ADC_CLOCK_100M),
    .arst_n             (arst_n),
    .pwm_out            (pwm_out),
    .history            (history)
  );

  // ============================================================
  // delay table and speaker taps
  // ============================================================
  delay_table_loader u_delay_table_loader (
    .PWM_ADC_CLOCK_100M (PWM_ADC_CLOCK_100M),
    .arst_n             (arst_n),
    .delay_fifo         (delay_fifo),
    .delay_read         (delay_read),
    .delay_wr           (delay_wr)
  );

  // one tap per speaker, each keeps its own delay
  for (genvar k = 0; k < pwm_audio_pkg::NUM_CHANNELS; k++) begin : g_tap
    speaker_tap #(
      .CHANNEL (k)
    ) u_speaker_tap (
      .PWM_ADC_CLOCK_100M (PWM_ADC_CLOCK_100M),
      .arst_n             (arst_n),
      .delay_wr           (delay_wr),
      .history            (history),
      .speaker            (speakers[k])
    );
  end

endmodule : pwm_audio_top

`default_nettype wire

// File: hw/speaker_tap.sv
// one speaker channel whose output is pwm_out delayed by its stored delay plus two clocks
`timescale 1ns/1ps
`default_nettype none

module speaker_tap #(
  parameter int CHANNEL = 0                       // speaker index this tap answers to
) (
  input  wire logic                                  PWM_ADC_CLOCK_100M,
  input  wire logic                                  arst_n,
  input  wire pwm_audio_pkg::delay_wr_t              delay_wr,
  input  wire logic [pwm_audio_pkg::DELAY_DEPTH-1:0] history,
  output logic                                       speaker
);

  logic [pwm_audio_pkg::DELAY_W-1:0] delay;       // clocks behind history bit 0
  logic                              wr_hit;

  assign wr_hit = delay_wr.en &&
                  (delay_wr.chan == pwm_audio_pkg::CHAN_W'(CHANNEL));

  // ============================================================
  // delay register and tap
  // ============================================================
  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      delay   <= '0;                 // zero delay after reset
      speaker <= 1'b0;
    end else begin
      if (wr_hit) begin
        delay <= delay_wr.delay;     // new value used from next cycle
      end
      speaker <= history[delay];     // one history stage plus this register
    end
  end

endmodule : speaker_tap

`default_nettype wire

// File: hw/delay_table_loader.sv
// delay frame parser with no back-pressure that drops any entry past the eighth in a frame
`timescale 1ns/1ps
`default_nettype none

module delay_table_loader (
  input  wire logic                     PWM_ADC_CLOCK_100M,
  input  wire logic                     arst_n,
  input  wire pwm_audio_pkg::fifo_in_t  delay_fifo,   // show-ahead
  output logic                          delay_read,   // consume every word
  output pwm_audio_pkg::delay_wr_t      delay_wr      // registered write strobe
);

  typedef enum logic {
    ST_IDLE    = 1'b0,                    // waiting for opening marker
    ST_LOADING = 1'b1                     // inside a frame
  } state_t;

  state_t                        state;
  logic [pwm_audio_pkg::CHAN_W:0] idx;     // one extra bit to count past the last channel
  logic                          is_marker;
  logic                          idx_ok;

  // no back-pressure so every word goes in its own cycle
  assign delay_read = arst_n && delay_fifo.avail;   // held low in reset

  assign is_marker = (delay_fifo.data == pwm_audio_pkg::FRAME_MARKER);
  assign idx_ok    = (idx < pwm_audio_pkg::NUM_CHANNELS);

  // ============================================================
  // frame state machine
  // ============================================================
  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      idx      <= '0;
      delay_wr <= '0;
    end else begin
      delay_wr.en <= 1'b0;                // strobe defaults low
      if (delay_fifo.avail) begin
        case (state)
          ST_IDLE: begin
            if (is_marker) begin
              state <= ST_LOADING;        // frame opens
              idx   <= '0;
            end
            // stray words outside a frame are dropped
          end
          ST_LOADING: begin
            if (is_marker) begin
              state <= ST_IDLE;           // frame closes
            end else if (idx_ok) begin
              delay_wr.en    <= 1'b1;
              delay_wr.chan  <= idx[pwm_audio_pkg::CHAN_W-1:0];
              delay_wr.delay <= delay_fifo.data[pwm_audio_pkg::DELAY_W-1:0];
              idx            <= idx + 1'b1;
            end
            // past channel 7 the word is ignored until the closing marker
          end
          default: begin
            state <= ST_IDLE;
          end
        endcase
      end
    end
  end

endmodule : delay_table_loader

`default_nettype wire

// File: hw/delay_line.sv
// pulse history of DELAY_DEPTH bits and delays beyond DELAY_DEPTH-1 cannot be represented
`timescale 1ns/1ps
`default_nettype none

module delay_line (
  input  wire logic                                  PWM_ADC_CLOCK_100M,
  input  wire logic                                  arst_n,
  input  wire logic                                  pwm_out,
  output logic [pwm_audio_pkg::DELAY_DEPTH-1:0]      history    // newest at bit 0
);

  // ============================================================
  // shift history
  // ============================================================

  // bit 0 is pwm_out one cycle ago and bit n is n+1 cycles ago
  // cleared in reset so taps read silence and not X
  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      history <= '0;
    end else begin
      history <= {history[pwm_audio_pkg::DELAY_DEPTH-2:0], pwm_out};  // shift up
    end
  end

endmodule : delay_line

`default_nettype wire

// File: hw/pwm_modulator.sv
// first-order pulse density modulator and a sample above DELTA gives a saturated stream
`timescale 1ns/1ps
`default_nettype none

module pwm_modulator (
  input  wire logic                               PWM_ADC_CLOCK_100M,
  input  wire logic                               arst_n,
  input  wire logic [pwm_audio_pkg::SAMPLE_W-1:0] sample,
  output logic                                    pwm_out      // density sample/DELTA
);

  logic [pwm_audio_pkg::ACC_W-1:0] acc;
  logic [pwm_audio_pkg::ACC_W-1:0] acc_base;     // after threshold subtract
  logic [pwm_audio_pkg::ACC_W-1:0] sample_ext;
  logic                            over_th;

  // zero extend sample to accumulator width
  assign sample_ext = {{(pwm_audio_pkg::ACC_W - pwm_audio_pkg::SAMPLE_W){1'b0}}, sample};

  // ============================================================
  // threshold and accumulate
  // ============================================================
  assign over_th  = (acc >= pwm_audio_pkg::DELTA);
  assign acc_base = over_th ? (acc - pwm_audio_pkg::DELTA) : acc;

  // acc stays below 2*DELTA so ACC_W bits are enough
  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      acc     <= '0;
      pwm_out <= 1'b0;
    end else begin
      acc     <= acc_base + sample_ext;     // new sample seen one cycle after load
      pwm_out <= over_th;                   // pulse when threshold crossed
    end
  end

endmodule : pwm_modulator

`default_nettype wire

// File: hw/sample_fetch.sv
// fetches one audio word every SAMPLE_PERIOD clocks only when the show-ahead FIFO reports avail
`timescale 1ns/1ps
`default_nettype none

module sample_fetch (
  input  wire logic                               PWM_ADC_CLOCK_100M,
  input  wire logic                               arst_n,
  input  wire pwm_audio_pkg::fifo_in_t            audio_fifo,   // show-ahead
  output logic                                    audio_read,   // one-cycle strobe
  output logic [pwm_audio_pkg::SAMPLE_W-1:0]      sample        // held between reads
);

  // ============================================================
  // sample period counter
  // ============================================================
  logic [pwm_audio_pkg::SAMPLE_CNT_W-1:0] period_cnt;
  logic                                   period_wrap;

  assign period_wrap = (period_cnt == pwm_audio_pkg::SAMPLE_LAST);

  // free running 0 .. SAMPLE_PERIOD-1
  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      period_cnt <= '0;
    end else if (period_wrap) begin
      period_cnt <= '0;                       // wrap
    end else begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

  // ============================================================
  // read strobe and sample capture
  // ============================================================

  // wrap cycle only, skipped when fifo is empty
  // counter is 0 in reset so the strobe stays low there
  assign audio_read = period_wrap && audio_fifo.avail;

  // capture on the edge that ends the read cycle
  always_ff @(posedge PWM_ADC_CLOCK_100M or negedge arst_n) begin
    if (!arst_n) begin
      sample <= '0;                           // silence until first read
    end else if (audio_read) begin
      sample <= audio_fifo.data[pwm_audio_pkg::SAMPLE_W-1:0];  // low bits only
    end
  end

endmodule : sample_fetch

`default_nettype wire

// File: hw/pwm_audio_pkg.sv
// shared constants and structs of the speaker player where samples must stay within 0 to 1000
`default_nettype none

package pwm_audio_pkg;

  // ============================================================
  // sample path
  // ============================================================
  localparam int SAMPLE_PERIOD = 1000;              // clocks per audio sample
  localparam int SAMPLE_W      = 10;                // valid range 0 to 1000
  localparam int SAMPLE_CNT_W  = $clog2(SAMPLE_PERIOD);
  localparam logic [SAMPLE_CNT_W-1:0] SAMPLE_LAST = SAMPLE_CNT_W'(SAMPLE_PERIOD - 1);

  // modulator accumulator never exceeds 2*DELTA-1
  localparam int ACC_W = 11;
  localparam logic [ACC_W-1:0] DELTA = ACC_W'(1000);

  // ============================================================
  // fifo words and delay table
  // ============================================================
  localparam int FIFO_W       = 32;
  localparam int DELAY_DEPTH  = 1024;               // pulse history length
  localparam int DELAY_W      = 10;                 // low bits of a delay word
  localparam int NUM_CHANNELS = 8;                  // speaker count
  localparam int CHAN_W       = 3;

  // opens and closes a delay frame
  localparam logic [FIFO_W-1:0] FRAME_MARKER = FIFO_W'(233333);

  // show-ahead fifo output as seen by the consumer
  typedef struct packed {
    logic              avail;                       // data valid
    logic [FIFO_W-1:0] data;
  } fifo_in_t;

  // one delay table write, broadcast to every tap
  typedef struct packed {
    logic               en;
    logic [CHAN_W-1:0]  chan;                       // target speaker
    logic [DELAY_W-1:0] delay;                      // in clocks
  } delay_wr_t;

endpackage : pwm_audio_pkg

`default_nettype wire
